// File: tcb_trace_top.f
+incdir+hw
hw/tcb_trace_pkg.sv
hw/tcb_capture.sv
hw/trace_decode.sv
hw/trace_fifo.sv
hw/tcb_trace_top.sv
verif/tcb_trace_tb.sv

// File: Makefile
# Verilator build and run for the TCB trace unit

VERILATOR ?= verilator
TOP       ?= tcb_trace_tb
FILELIST  ?= tcb_trace_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TB FAILED

# sources come from the file list, include directories dropped
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hw/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tcb_trace_tb.sv
// TCB trace unit testbench

`timescale 1ns/10ps
`include "tcb_trace_macros.svh"

module tcb_trace_tb;

  localparam int CLK_NS = 4;
  // rough cycle budget per test, plus margin
  localparam int RUN_CYCLES = 100 + 100 + 80 + 400 + 120 + 60;
  localparam int MARGIN_CYCLES = 300;

  // one expected record
  typedef struct packed {
    logic [1:0]             kind;
    logic                   wen;
    logic [`TCB_AW-1:0]     adr;
    logic [`TCB_DW-1:0]     dat;
    logic                   err;
    logic                   bad;
    logic [`TRC_INFO_W-1:0] info;
  } rec_t;

  logic                     bus = 1'b0;
  logic                     rst;
  logic                     bus_vld;
  logic                     bus_rdy;
  logic                     bus_wen;
  logic [`TCB_AW-1:0]       bus_adr;
  logic [`TCB_BW-1:0]       bus_ben;
  logic [`TCB_DW-1:0]       bus_wdt;
  logic [`TCB_DW-1:0]       bus_rdt;
  logic                     bus_err;
  logic                     dbg_ifu;
  logic                     dbg_lsu;
  logic                     dbg_gpr;
  logic                     trc_rd;
  logic                     trc_empty;
  tcb_trace_pkg::rec_kind_t trc_kind;
  logic                     trc_wen;
  logic [`TCB_AW-1:0]       trc_adr;
  logic [`TCB_DW-1:0]       trc_dat;
  logic                     trc_err;
  logic                     trc_bad;
  logic [`TRC_INFO_W-1:0]   trc_info;
  logic                     trc_overflow;
  logic [`TRC_CNT_W-1:0]    trc_drop_cnt;
  logic [`TRC_CNT_W-1:0]    cnt_ifu;
  logic [`TRC_CNT_W-1:0]    cnt_lsu;
  logic [`TRC_CNT_W-1:0]    cnt_gpr;

  // response of the last accepted transfer, driven one cycle later
  logic [`TCB_DW-1:0]       pend_rdt;
  logic                     pend_err;
  rec_t                     exp_q [$];
  int                       kind_total [3] = '{0, 0, 0};
  int                       errors = 0;
  int                       checks = 0;
  integer                   seed = 32'he51b;

  always #(CLK_NS / 2) bus = ~bus;

  tcb_trace_top dut0 (.*);

  //////////////////////////////
  // reference model
  //////////////////////////////

  // major opcode from instruction bits 6..2
  function automatic logic [4:0] opcode_class(input logic [31:0] word);
    case (word[6:2])
      5'b00000: return 5'(tcb_trace_pkg::OPC_LOAD);
      5'b01000: return 5'(tcb_trace_pkg::OPC_STORE);
      5'b00100: return 5'(tcb_trace_pkg::OPC_OP_IMM);
      5'b01100: return 5'(tcb_trace_pkg::OPC_OP);
      5'b11000: return 5'(tcb_trace_pkg::OPC_BRANCH);
      5'b11011: return 5'(tcb_trace_pkg::OPC_JAL);
      5'b11001: return 5'(tcb_trace_pkg::OPC_JALR);
      5'b01101: return 5'(tcb_trace_pkg::OPC_LUI);
      5'b00101: return 5'(tcb_trace_pkg::OPC_AUIPC);
      5'b11100: return 5'(tcb_trace_pkg::OPC_SYSTEM);
      default:  return 5'(tcb_trace_pkg::OPC_OTHER);
    endcase
  endfunction

  // aligned 1, 2 or 4 byte groups, anything else irregular
  function automatic logic [4:0] access_size(input logic [3:0] ben);
    if ($countones(ben) == 1) begin
      return 5'(tcb_trace_pkg::SIZE_BYTE);
    end else if (ben == 4'b0011 || ben == 4'b1100) begin
      return 5'(tcb_trace_pkg::SIZE_HALF);
    end else if (ben == 4'b1111) begin
      return 5'(tcb_trace_pkg::SIZE_WORD);
    end
    return 5'(tcb_trace_pkg::SIZE_IRREG);
  endfunction

  // dbg is {ifu, lsu, gpr}, fetch first
  task automatic predict_rec(input logic [2:0] dbg, input logic wen, input logic [31:0] adr,
                             input logic [3:0] ben, input logic [31:0] wdt,
                             input logic [31:0] rdt, input logic err);
    rec_t r;
    begin
      r.wen = wen;
      r.adr = adr;
      r.dat = wen ? wdt : rdt;
      r.err = err;
      r.bad = !wen && (ben == 4'b0000);
      if (dbg[2]) begin
        r.kind = tcb_trace_pkg::KIND_IFU;
        r.info = opcode_class(r.dat);
        kind_total[0]++;
      end else if (dbg[1]) begin
        r.kind = tcb_trace_pkg::KIND_LSU;
        r.info = access_size(ben);
        kind_total[1]++;
      end else if (dbg[0]) begin
        r.kind = tcb_trace_pkg::KIND_GPR;
        r.info = adr[6:2];
        kind_total[2]++;
      end
      // no indicator, no record
      if (dbg != 3'b000) begin
        exp_q.push_back(r);
      end
    end
  endtask

  //////////////////////////////
  // drivers
  //////////////////////////////

  // falling edge, previous response out, bus idle by default
  task automatic next_cycle();
    begin
      @(negedge bus);
      bus_rdt  = pend_rdt;
      bus_err  = pend_err;
      // junk outside the response cycle
      pend_rdt = $random(seed);
      pend_err = 1'($random(seed));
      bus_vld  = 1'b0;
      bus_rdy  = 1'($random(seed));
      trc_rd   = 1'b0;
    end
  endtask

  // one transfer, held with rdy low for stall cycles
  task automatic send_xfer(input logic [2:0] dbg, input logic wen, input logic [31:0] adr,
                           input logic [3:0] ben, input logic [31:0] wdt,
                           input logic [31:0] rdt, input logic err, input int stall);
    begin
      for (int i = 0; i <= stall; i++) begin
        next_cycle();
        {dbg_ifu, dbg_lsu, dbg_gpr} = dbg;
        bus_vld = 1'b1;
        bus_rdy = (i == stall);
        bus_wen = wen;
        bus_adr = adr;
        bus_ben = ben;
        bus_wdt = wdt;
      end
      pend_rdt = rdt;
      pend_err = err;
      predict_rec(dbg, wen, adr, ben, wdt, rdt, err);
    end
  endtask

  //////////////////////////////
  // checkers
  //////////////////////////////

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    begin
      checks++;
      assert (got === want) else begin
        errors++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      end
    end
  endtask

  task automatic compare_record(input rec_t want);
    begin
      compare_field("trc_kind", 32'(trc_kind), 32'(want.kind));
      compare_field("trc_wen", 32'(trc_wen), 32'(want.wen));
      compare_field("trc_adr", trc_adr, want.adr);
      compare_field("trc_dat", trc_dat, want.dat);
      compare_field("trc_err", 32'(trc_err), 32'(want.err));
      compare_field("trc_bad", 32'(trc_bad), 32'(want.bad));
      compare_field("trc_info", 32'(trc_info), 32'(want.info));
    end
  endtask

  task automatic compare_counters();
    begin
      compare_field("cnt_ifu", 32'(cnt_ifu), 32'(kind_total[0]));
      compare_field("cnt_lsu", 32'(cnt_lsu), 32'(kind_total[1]));
      compare_field("cnt_gpr", 32'(cnt_gpr), 32'(kind_total[2]));
    end
  endtask

  // pop and compare every expected record, then expect nothing more
  task automatic drain_fifo();
    rec_t want;
    int   waited;
    begin
      while (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        waited = 0;
        next_cycle();
        while (trc_empty && waited < 16) begin
          next_cycle();
          waited++;
        end
        checks++;
        assert (!trc_empty) else begin
          errors++;
          $display("no record showed up at %0t although one was expected", $time);
        end
        if (!trc_empty) begin
          compare_record(want);
          trc_rd = 1'b1;
        end
      end
      repeat (6) next_cycle();
      checks++;
      assert (trc_empty) else begin
        errors++;
        $display("extra record left in the FIFO at %0t", $time);
      end
      // resync after a surplus record
      while (!trc_empty) begin
        trc_rd = 1'b1;
        next_cycle();
      end
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic fetch_decoding();
    logic [31:0] words [11];
    begin
      // addi lw sw add beq jal jalr lui auipc ecall fence
      words = '{32'h00500093, 32'h0000a103, 32'h00112023, 32'h002081b3,
                32'h00208463, 32'h008000ef, 32'h000080e7, 32'h123452b7,
                32'h00001297, 32'h00000073, 32'h0000000f};
      for (int i = 0; i < 11; i++) begin
        send_xfer(3'b100, 1'b0, 32'h0000_1000 + 32'(i * 4), 4'b1111, $random(seed),
                  words[i], 1'(i % 4 == 3), 0);
        // read out before the FIFO fills up
        if (exp_q.size() == `TRC_DEPTH) begin
          drain_fifo();
        end
      end
      drain_fifo();
    end
  endtask

  task automatic load_store_sizes();
    logic [3:0] lanes [4];
    begin
      lanes = '{4'b0001, 4'b0011, 4'b1111, 4'b0110};
      for (int i = 0; i < 4; i++) begin
        send_xfer(3'b010, 1'b0, 32'h2000_0000 + 32'(i * 16), lanes[i], $random(seed),
                  $random(seed), 1'b0, 0);
        send_xfer(3'b010, 1'b1, 32'h2000_0004 + 32'(i * 16), lanes[i], $random(seed),
                  $random(seed), 1'(i == 2), 0);
      end
      // eight records, FIFO is full now
      drain_fifo();
      // read without lanes is a fault, a write is not
      send_xfer(3'b010, 1'b0, 32'h2000_0100, 4'b0000, $random(seed), $random(seed), 1'b0, 0);
      send_xfer(3'b010, 1'b1, 32'h2000_0104, 4'b0000, $random(seed), $random(seed), 1'b1, 0);
      drain_fifo();
    end
  endtask

  task automatic register_priority();
    int idx [4];
    begin
      idx = '{0, 5, 17, 31};
      // upper address bits set, only 6..2 are the index
      for (int i = 0; i < 4; i++) begin
        send_xfer(3'b001, 1'(i % 2), 32'hffff_ff80 | (32'(idx[i]) << 2), 4'b1111,
                  $random(seed), $random(seed), 1'b0, 0);
      end
      send_xfer(3'b111, 1'b0, 32'h0000_1040, 4'b1111, $random(seed), 32'h00000013, 1'b0, 0);
      send_xfer(3'b011, 1'b1, 32'h2000_0008, 4'b1100, $random(seed), $random(seed), 1'b0, 0);
      send_xfer(3'b101, 1'b0, 32'h0000_1044, 4'b1111, $random(seed), 32'h0000006f, 1'b0, 0);
      send_xfer(3'b110, 1'b0, 32'h0000_1048, 4'b0001, $random(seed), 32'h00000073, 1'b0, 0);
      send_xfer(3'b000, 1'b0, 32'h0000_104c, 4'b1111, $random(seed), $random(seed), 1'b0, 0);
      drain_fifo();
    end
  endtask

  task automatic back_to_back_order();
    int stall;
    int gap;
    begin
      // batches stay under the FIFO depth
      for (int b = 0; b < 5; b++) begin
        for (int n = 0; n < 6; n++) begin
          stall = (($random(seed) & 3) == 0) ? 1 : 0;
          gap = (($random(seed) & 3) == 0) ? 2 : 0;
          send_xfer(3'($random(seed)), 1'($random(seed)), $random(seed), 4'($random(seed)),
                    $random(seed), $random(seed), 1'($random(seed)), stall);
          repeat (gap) next_cycle();
        end
        drain_fifo();
      end
      compare_counters();
    end
  endtask

  task automatic overflow_drop();
    begin
      compare_field("trc_overflow", 32'(trc_overflow), 32'd0);
      for (int i = 0; i < 10; i++) begin
        send_xfer(3'(3'b001 << (i % 3)), 1'(i % 2), 32'h3000_0000 + 32'(i * 4), 4'b1111,
                  $random(seed), $random(seed), 1'b0, 0);
      end
      // last record through all three stages
      repeat (4) next_cycle();
      while (exp_q.size() > `TRC_DEPTH) begin
        exp_q.delete(exp_q.size() - 1);
      end
      compare_field("trc_drop_cnt", 32'(trc_drop_cnt), 32'd2);
      compare_field("trc_overflow", 32'(trc_overflow), 32'd1);
      drain_fifo();
      compare_counters();
    end
  endtask

  task automatic record_latency();
    begin
      repeat (8) next_cycle();
      send_xfer(3'b001, 1'b0, 32'h0000_0044, 4'b1111, $random(seed), $random(seed), 1'b0, 0);
      // empty for three edges after acceptance, then the record shows
      for (int k = 0; k < 4; k++) begin
        next_cycle();
        compare_field("trc_empty", 32'(trc_empty), 32'(k < 3));
      end
      drain_fifo();
    end
  endtask

  //////////////////////////////
  // run control
  //////////////////////////////

  initial begin : watchdog
    #(CLK_NS * (RUN_CYCLES + MARGIN_CYCLES));
    $display("watchdog expired at %0t, tests did not complete", $time);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst      = 1'b1;
    bus_vld  = 1'b0;
    bus_rdy  = 1'b0;
    bus_wen  = 1'b0;
    bus_adr  = '0;
    bus_ben  = '0;
    bus_wdt  = '0;
    bus_rdt  = '0;
    bus_err  = 1'b0;
    dbg_ifu  = 1'b0;
    dbg_lsu  = 1'b0;
    dbg_gpr  = 1'b0;
    trc_rd   = 1'b0;
    pend_rdt = '0;
    pend_err = 1'b0;
    repeat (4) @(posedge bus);
    @(negedge bus);
    rst = 1'b0;
    // state right after reset
    compare_field("trc_empty", 32'(trc_empty), 32'd1);
    compare_field("trc_overflow", 32'(trc_overflow), 32'd0);
    compare_field("trc_drop_cnt", 32'(trc_drop_cnt), 32'd0);
    compare_counters();
    fetch_decoding();
    load_store_sizes();
    register_priority();
    back_to_back_order();
    overflow_drop();
    record_latency();
    compare_counters();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: hw/tcb_trace_top.sv
// TCB trace unit top level

`timescale 1ns/10ps
`include "tcb_trace_macros.svh"

module tcb_trace_top (
  input  logic                     bus,
  input  logic                     rst,
  // monitored bus
  input  logic                     bus_vld,
  input  logic                     bus_rdy,
  input  logic                     bus_wen,
  input  logic [`TCB_AW-1:0]       bus_adr,
  input  logic [`TCB_BW-1:0]       bus_ben,
  input  logic [`TCB_DW-1:0]       bus_wdt,
  input  logic [`TCB_DW-1:0]       bus_rdt,
  input  logic                     bus_err,
  input  logic                     dbg_ifu,
  input  logic                     dbg_lsu,
  input  logic                     dbg_gpr,
  // host side
  input  logic                     trc_rd,
  output logic                     trc_empty,
  output tcb_trace_pkg::rec_kind_t trc_kind,
  output logic                     trc_wen,
  output logic [`TCB_AW-1:0]       trc_adr,
  output logic [`TCB_DW-1:0]       trc_dat,
  output logic                     trc_err,
  output logic                     trc_bad,
  output logic [`TRC_INFO_W-1:0]   trc_info,
  output logic                     trc_overflow,
  output logic [`TRC_CNT_W-1:0]    trc_drop_cnt,
  // statistics
  output logic [`TRC_CNT_W-1:0]    cnt_ifu,
  output logic [`TRC_CNT_W-1:0]    cnt_lsu,
  output logic [`TRC_CNT_W-1:0]    cnt_gpr
);

  // capture to decode
  logic                     cap_vld;
  tcb_trace_pkg::rec_kind_t cap_kind;
  logic                     cap_wen;
  logic [`TCB_AW-1:0]       cap_adr;
  logic [`TCB_BW-1:0]       cap_ben;
  logic [`TCB_DW-1:0]       cap_dat;
  logic                     cap_err;
  logic                     cap_bad;
  // decode to FIFO
  logic                     dec_vld;
  tcb_trace_pkg::rec_kind_t dec_kind;
  logic                     dec_wen;
  logic [`TCB_AW-1:0]       dec_adr;
  logic [`TCB_DW-1:0]       dec_dat;
  logic                     dec_err;
  logic                     dec_bad;
  logic [`TRC_INFO_W-1:0]   dec_info;

  tcb_capture capture0 (
    .bus      (bus),      .rst      (rst),
    .bus_vld  (bus_vld),  .bus_rdy  (bus_rdy),  .bus_wen  (bus_wen),
    .bus_adr  (bus_adr),  .bus_ben  (bus_ben),  .bus_wdt  (bus_wdt),
    .bus_rdt  (bus_rdt),  .bus_err  (bus_err),
    .dbg_ifu  (dbg_ifu),  .dbg_lsu  (dbg_lsu),  .dbg_gpr  (dbg_gpr),
    .cap_vld  (cap_vld),  .cap_kind (cap_kind), .cap_wen  (cap_wen),
    .cap_adr  (cap_adr),  .cap_ben  (cap_ben),  .cap_dat  (cap_dat),
    .cap_err  (cap_err),  .cap_bad  (cap_bad)
  );

  trace_decode decode0 (
    .bus      (bus),      .rst      (rst),
    .cap_vld  (cap_vld),  .cap_kind (cap_kind), .cap_wen  (cap_wen),
    .cap_adr  (cap_adr),  .cap_ben  (cap_ben),  .cap_dat  (cap_dat),
    .cap_err  (cap_err),  .cap_bad  (cap_bad),
    .dec_vld  (dec_vld),  .dec_kind (dec_kind), .dec_wen  (dec_wen),
    .dec_adr  (dec_adr),  .dec_dat  (dec_dat),  .dec_err  (dec_err),
    .dec_bad  (dec_bad),  .dec_info (dec_info),
    .cnt_ifu  (cnt_ifu),  .cnt_lsu  (cnt_lsu),  .cnt_gpr  (cnt_gpr)
  );

  trace_fifo fifo0 (
    .bus          (bus),          .rst          (rst),
    .dec_vld      (dec_vld),      .dec_kind     (dec_kind),
    .dec_wen      (dec_wen),      .dec_adr      (dec_adr),
    .dec_dat      (dec_dat),      .dec_err      (dec_err),
    .dec_bad      (dec_bad),      .dec_info     (dec_info),
    .trc_rd       (trc_rd),       .trc_empty    (trc_empty),
    .trc_kind     (trc_kind),     .trc_wen      (trc_wen),
    .trc_adr      (trc_adr),      .trc_dat      (trc_dat),
    .trc_err      (trc_err),      .trc_bad      (trc_bad),
    .trc_info     (trc_info),     .trc_overflow (trc_overflow),
    .trc_drop_cnt (trc_drop_cnt)
  );

endmodule

// File: hw/trace_fifo.sv
// trace record FIFO

`timescale 1ns/10ps
`include "tcb_trace_macros.svh"

module trace_fifo (
  input  logic                     bus,
  input  logic                     rst,
  // from decode
  input  logic                     dec_vld,
  input  tcb_trace_pkg::rec_kind_t dec_kind,
  input  logic                     dec_wen,
  input  logic [`TCB_AW-1:0]       dec_adr,
  input  logic [`TCB_DW-1:0]       dec_dat,
  input  logic                     dec_err,
  input  logic                     dec_bad,
  input  logic [`TRC_INFO_W-1:0]   dec_info,
  // host side
  input  logic                     trc_rd,
  output logic                     trc_empty,
  output tcb_trace_pkg::rec_kind_t trc_kind,
  output logic                     trc_wen,
  output logic [`TCB_AW-1:0]       trc_adr,
  output logic [`TCB_DW-1:0]       trc_dat,
  output logic                     trc_err,
  output logic                     trc_bad,
  output logic [`TRC_INFO_W-1:0]   trc_info,
  output logic                     trc_overflow,
  output logic [`TRC_CNT_W-1:0]    trc_drop_cnt
);

  localparam int PTR_W = $clog2(`TRC_DEPTH);

  // record storage, one array per field
  tcb_trace_pkg::rec_kind_t mem_kind [`TRC_DEPTH];
  logic                     mem_wen  [`TRC_DEPTH];
  logic [`TCB_AW-1:0]       mem_adr  [`TRC_DEPTH];
  logic [`TCB_DW-1:0]       mem_dat  [`TRC_DEPTH];
  logic                     mem_err  [`TRC_DEPTH];
  logic                     mem_bad  [`TRC_DEPTH];
  logic [`TRC_INFO_W-1:0]   mem_info [`TRC_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W:0]           count;
  logic                     full;
  logic                     push;
  logic                     pop;
  logic                     drop;

  assign trc_empty = (count == '0);
  // depth is a power of two, top count bit means full
  assign full = count[PTR_W];
  assign pop  = trc_rd & ~trc_empty;
  // a pop in the same cycle frees a slot
  assign push = dec_vld & (~full | pop);
  assign drop = dec_vld & full & ~pop;

  always_ff @(posedge bus) begin
    if (push) begin
      mem_kind[wr_ptr] <= dec_kind;
      mem_wen[wr_ptr]  <= dec_wen;
      mem_adr[wr_ptr]  <= dec_adr;
      mem_dat[wr_ptr]  <= dec_dat;
      mem_err[wr_ptr]  <= dec_err;
      mem_bad[wr_ptr]  <= dec_bad;
      mem_info[wr_ptr] <= dec_info;
    end
  end

  // pointers wrap on their own
  always_ff @(posedge bus) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // drop accounting
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      trc_drop_cnt <= '0;
      trc_overflow <= 1'b0;
    end else if (drop) begin
      if (trc_drop_cnt != '1) begin
        trc_drop_cnt <= trc_drop_cnt + 1'b1;
      end
      // sticky until reset
      trc_overflow <= 1'b1;
    end
  end

  // show-ahead head entry
  assign trc_kind = mem_kind[rd_ptr];
  assign trc_wen  = mem_wen[rd_ptr];
  assign trc_adr  = mem_adr[rd_ptr];
  assign trc_dat  = mem_dat[rd_ptr];
  assign trc_err  = mem_err[rd_ptr];
  assign trc_bad  = mem_bad[rd_ptr];
  assign trc_info = mem_info[rd_ptr];

  occupancy_bound: assert property (@(posedge bus) disable iff (rst)
    count <= (PTR_W+1)'(`TRC_DEPTH));

endmodule

// File: hw/trace_decode.sv
// trace record decode and statistics

`timescale 1ns/10ps
`include "tcb_trace_macros.svh"

module trace_decode (
  input  logic                     bus,
  input  logic                     rst,
  // from capture
  input  logic                     cap_vld,
  input  tcb_trace_pkg::rec_kind_t cap_kind,
  input  logic                     cap_wen,
  input  logic [`TCB_AW-1:0]       cap_adr,
  input  logic [`TCB_BW-1:0]       cap_ben,
  input  logic [`TCB_DW-1:0]       cap_dat,
  input  logic                     cap_err,
  input  logic                     cap_bad,
  // decoded record
  output logic                     dec_vld,
  output tcb_trace_pkg::rec_kind_t dec_kind,
  output logic                     dec_wen,
  output logic [`TCB_AW-1:0]       dec_adr,
  output logic [`TCB_DW-1:0]       dec_dat,
  output logic                     dec_err,
  output logic                     dec_bad,
  output logic [`TRC_INFO_W-1:0]   dec_info,
  // per-class record counts
  output logic [`TRC_CNT_W-1:0]    cnt_ifu,
  output logic [`TRC_CNT_W-1:0]    cnt_lsu,
  output logic [`TRC_CNT_W-1:0]    cnt_gpr
);

  tcb_trace_pkg::rv_opc_t   opc;
  tcb_trace_pkg::acc_size_t size;
  logic [`TRC_INFO_W-1:0]   info;
  // one hit bit per class, ifu at bit 0
  logic [2:0]               hit;
  logic [`TRC_CNT_W-1:0]    cnt [3];

  //////////////////////////////
  // info field
  //////////////////////////////

  // major opcode, instruction bits 6..2
  always_comb begin
    case (cap_dat[6:2])
      tcb_trace_pkg::OPC_LOAD:   opc = tcb_trace_pkg::OPC_LOAD;
      tcb_trace_pkg::OPC_STORE:  opc = tcb_trace_pkg::OPC_STORE;
      tcb_trace_pkg::OPC_OP_IMM: opc = tcb_trace_pkg::OPC_OP_IMM;
      tcb_trace_pkg::OPC_OP:     opc = tcb_trace_pkg::OPC_OP;
      tcb_trace_pkg::OPC_BRANCH: opc = tcb_trace_pkg::OPC_BRANCH;
      tcb_trace_pkg::OPC_JAL:    opc = tcb_trace_pkg::OPC_JAL;
      tcb_trace_pkg::OPC_JALR:   opc = tcb_trace_pkg::OPC_JALR;
      tcb_trace_pkg::OPC_LUI:    opc = tcb_trace_pkg::OPC_LUI;
      tcb_trace_pkg::OPC_AUIPC:  opc = tcb_trace_pkg::OPC_AUIPC;
      tcb_trace_pkg::OPC_SYSTEM: opc = tcb_trace_pkg::OPC_SYSTEM;
      default:                   opc = tcb_trace_pkg::OPC_OTHER;
    endcase
  end

  // access size from the byte lanes, aligned groups only
  always_comb begin
    case (cap_ben)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: size = tcb_trace_pkg::SIZE_BYTE;
      4'b0011, 4'b1100:                   size = tcb_trace_pkg::SIZE_HALF;
      4'b1111:                            size = tcb_trace_pkg::SIZE_WORD;
      default:                            size = tcb_trace_pkg::SIZE_IRREG;
    endcase
  end

  always_comb begin
    case (cap_kind)
      tcb_trace_pkg::KIND_IFU: info = opc;
      tcb_trace_pkg::KIND_LSU: info = `TRC_INFO_W'(size);
      // register index sits in word address bits
      default:                 info = cap_adr[6:2];
    endcase
  end

  //////////////////////////////
  // record register
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      dec_vld <= 1'b0;
    end else begin
      dec_vld <= cap_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (cap_vld) begin
      dec_kind <= cap_kind;
      dec_wen  <= cap_wen;
      dec_adr  <= cap_adr;
      dec_dat  <= cap_dat;
      dec_err  <= cap_err;
      dec_bad  <= cap_bad;
      dec_info <= info;
    end
  end

  //////////////////////////////
  // counters
  //////////////////////////////

  assign hit = {cap_kind == tcb_trace_pkg::KIND_GPR,
                cap_kind == tcb_trace_pkg::KIND_LSU,
                cap_kind == tcb_trace_pkg::KIND_IFU};

  // saturating, hold at all ones
  always_ff @(posedge bus) begin
    if (rst) begin
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else if (cap_vld) begin
      for (int i = 0; i < 3; i++) begin
        if (hit[i] && (cnt[i] != '1)) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_ifu = cnt[0];
  assign cnt_lsu = cnt[1];
  assign cnt_gpr = cnt[2];

  // every record lands in exactly one counter
  cap_one_class: assert property (@(posedge bus) disable iff (rst)
    cap_vld |-> $onehot(hit));

endmodule

// File: hw/tcb_capture.sv
// TCB request/response capture

`timescale 1ns/10ps
`include "tcb_trace_macros.svh"

module tcb_capture (
  input  logic                     bus,
  input  logic                     rst,
  // monitored bus, sampled only
  input  logic                     bus_vld,
  input  logic                     bus_rdy,
  input  logic                     bus_wen,
  input  logic [`TCB_AW-1:0]       bus_adr,
  input  logic [`TCB_BW-1:0]       bus_ben,
  input  logic [`TCB_DW-1:0]       bus_wdt,
  input  logic [`TCB_DW-1:0]       bus_rdt,
  input  logic                     bus_err,
  // debug indicators, qualified by the request
  input  logic                     dbg_ifu,
  input  logic                     dbg_lsu,
  input  logic                     dbg_gpr,
  // joined transfer
  output logic                     cap_vld,
  output tcb_trace_pkg::rec_kind_t cap_kind,
  output logic                     cap_wen,
  output logic [`TCB_AW-1:0]       cap_adr,
  output logic [`TCB_BW-1:0]       cap_ben,
  output logic [`TCB_DW-1:0]       cap_dat,
  output logic                     cap_err,
  output logic                     cap_bad
);

  logic                     bus_acc;
  logic                     bus_dbg;
  tcb_trace_pkg::rec_kind_t bus_kind;
  // request held while the response is in flight
  logic                     req_rec;
  tcb_trace_pkg::rec_kind_t req_kind;
  logic                     req_wen;
  logic [`TCB_AW-1:0]       req_adr;
  logic [`TCB_BW-1:0]       req_ben;
  logic [`TCB_DW-1:0]       req_wdt;

  //////////////////////////////
  // request phase
  //////////////////////////////

  assign bus_acc = bus_vld & bus_rdy;
  // no indicator set, nothing to record
  assign bus_dbg = dbg_ifu | dbg_lsu | dbg_gpr;

  // fetch wins over load/store, load/store over register access
  always_comb begin
    if (dbg_ifu) begin
      bus_kind = tcb_trace_pkg::KIND_IFU;
    end else if (dbg_lsu) begin
      bus_kind = tcb_trace_pkg::KIND_LSU;
    end else if (dbg_gpr) begin
      bus_kind = tcb_trace_pkg::KIND_GPR;
    end else begin
      // unset kind, transfer is not recorded
      bus_kind = tcb_trace_pkg::rec_kind_t'(2'd0);
    end
  end

  always_ff @(posedge bus) begin
    if (rst) begin
      req_rec <= 1'b0;
    end else begin
      req_rec <= bus_acc & bus_dbg;
    end
  end

  always_ff @(posedge bus) begin
    if (bus_acc) begin
      req_kind <= bus_kind;
      req_wen  <= bus_wen;
      req_adr  <= bus_adr;
      req_ben  <= bus_ben;
      req_wdt  <= bus_wdt;
    end
  end

  //////////////////////////////
  // response phase
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      cap_vld <= 1'b0;
    end else begin
      cap_vld <= req_rec;
    end
  end

  // read data and error arrive one cycle after acceptance
  always_ff @(posedge bus) begin
    if (req_rec) begin
      cap_kind <= req_kind;
      cap_wen  <= req_wen;
      cap_adr  <= req_adr;
      cap_ben  <= req_ben;
      cap_dat  <= req_wen ? req_wdt : bus_rdt;
      cap_err  <= bus_err;
      // read without any byte lane is a protocol fault
      cap_bad  <= ~req_wen & ~|req_ben;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  bus_vld_known: assert property (@(posedge bus) disable iff (rst)
    !$isunknown(bus_vld));

  // a pulse always carries one of the three classes
  cap_kind_set: assert property (@(posedge bus) disable iff (rst)
    cap_vld |-> (cap_kind inside {tcb_trace_pkg::KIND_IFU,
                                  tcb_trace_pkg::KIND_LSU,
                                  tcb_trace_pkg::KIND_GPR}));

endmodule

// File: hw/tcb_trace_pkg.sv
// TCB trace record types

`include "tcb_trace_macros.svh"

package tcb_trace_pkg;

  //////////////////////////////
  // record kind
  //////////////////////////////

  // code zero left free, marks an unset kind
  typedef enum logic [1:0] {
    KIND_IFU = 2'd1,  // instruction fetch
    KIND_LSU = 2'd2,  // load/store
    KIND_GPR = 2'd3   // register file access
  } rec_kind_t;

  //////////////////////////////
  // major opcode class
  //////////////////////////////

  // instruction bits 6..2, same width as the info field
  typedef enum logic [`TRC_INFO_W-1:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011,
    OPC_SYSTEM = 5'b11100,
    // anything not listed above
    OPC_OTHER  = 5'b11111
  } rv_opc_t;

  //////////////////////////////
  // load/store access size
  //////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HALF  = 2'd1,
    SIZE_WORD  = 2'd2,
    SIZE_IRREG = 2'd3   // unaligned or empty enable pattern
  } acc_size_t;

endpackage

// File: hw/tcb_trace_macros.svh
// TCB trace widths and depth

`ifndef TCB_TRACE_MACROS_SVH
`define TCB_TRACE_MACROS_SVH

// bus address width
`define TCB_AW 32

// bus data width
`define TCB_DW 32

// byte enable width, one bit per data byte
`define TCB_BW 4

// decoded info field width
`define TRC_INFO_W 5

// per-class and drop counter width
`define TRC_CNT_W 16

// record FIFO depth, power of two
`define TRC_DEPTH 8

`endif
